/* hw/te_params.svh */
// trace packet emitter widths
// shared by the type package and every RTL block
`ifndef TE_PARAMS_SVH
`define TE_PARAMS_SVH

// instruction address width
`define TE_XLEN 64
// exception cause and privilege level
`define TE_CAUSE_LEN 5
`define TE_PRIV_LEN 2
// branch counter and branch map
`define TE_BRANCH_COUNT_LEN 5
`define TE_BRANCH_MAP_LEN 31
// log2 of irdepth width
`define TE_CALL_COUNTER_SIZE 3
// payload bits, byte length and used-bit counter
`define TE_PAYLOAD_LEN 160
`define TE_LEN_BITS 5
`define TE_USED_BITS 9

`endif

/* hw/te_pkg.sv */
// trace packet emitter types
// enums for packet fields, vectors for the widths that carry a meaning
`include "te_params.svh"

package te_pkg;

    // packet format, bits 1:0 of every payload
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'd0,
        F_DIFF_DELTA = 2'd1,
        F_ADDR_ONLY  = 2'd2,
        F_SYNC       = 2'd3
    } te_format_e;

    // format 3 subformat, bits 3:2
    typedef enum logic [1:0] {
        SF_START   = 2'd0,
        SF_TRAP    = 2'd1,
        SF_CONTEXT = 2'd2,
        SF_SUPPORT = 2'd3
    } te_sync_sf_e;

    // qualification status reported in support packets
    typedef enum logic [1:0] {
        QS_NO_CHANGE  = 2'd0,
        QS_ENDED_REP  = 2'd1,
        QS_TRACE_LOST = 2'd2,
        QS_ENDED_NTR  = 2'd3
    } te_qual_status_e;

    // instruction trace options
    typedef enum logic [2:0] {
        DELTA_ADDRESS      = 3'd0,
        FULL_ADDRESS       = 3'd1,
        IMPLICIT_EXCEPTION = 3'd2,
        SEQUENTIAL_JUMP    = 3'd3,
        IMPLICIT_RETURN    = 3'd4,
        BRANCH_PREDICTION  = 3'd5,
        JUMP_TARGET_CACHE  = 3'd6
    } te_ioptions_e;

    typedef logic [`TE_PRIV_LEN-1:0]         te_priv_t;
    typedef logic [`TE_XLEN-1:0]             te_addr_t;
    typedef logic [`TE_CAUSE_LEN-1:0]        te_cause_t;
    typedef logic [`TE_BRANCH_COUNT_LEN-1:0] te_branches_t;
    typedef logic [`TE_BRANCH_MAP_LEN-1:0]   te_branch_map_t;
    typedef logic [`TE_PAYLOAD_LEN-1:0]      te_payload_t;
    typedef logic [`TE_USED_BITS-1:0]        te_used_bits_t;
    typedef logic [`TE_LEN_BITS-1:0]         te_len_t;
    // keep_bits ranges 0..XLEN
    typedef logic [6:0]                      te_keep_bits_t;

endpackage

/* hw/te_req_if.sv */
// decoded packet request shared by the address stage and both packers
`include "te_params.svh"

interface te_req_if;
    import te_pkg::*;

    te_format_e            format;
    te_sync_sf_e           subformat;
    te_priv_t              priv;
    te_addr_t              iaddr;
    logic                  branch;
    logic                  branch_taken;
    // lc/tc exception info, picked by lc_tc_mux
    te_cause_t             lc_cause;
    te_addr_t              lc_tval;
    logic                  lc_interrupt;
    te_cause_t             tc_cause;
    te_addr_t              tc_tval;
    logic                  tc_interrupt;
    logic                  lc_tc_mux;
    // trap target sources
    logic                  thaddr;
    logic [`TE_XLEN-1:2]   tvec;
    te_addr_t              epc;
    // support packet fields
    logic                  ienable;
    logic                  encoder_mode;
    te_qual_status_e       qual_status;
    te_ioptions_e          ioptions;
    logic                  lc_updiscon;
    te_branches_t          branches;
    te_branch_map_t        branch_map;

    modport addr (input format, subformat, iaddr, thaddr, tvec, epc);

    modport sync (input format, subformat, priv, branch, branch_taken, lc_cause, lc_tval,
                  lc_interrupt, tc_cause, tc_tval, tc_interrupt, lc_tc_mux, thaddr,
                  ienable, encoder_mode, qual_status, ioptions);

    modport diff (input format, iaddr, lc_updiscon, branches, branch_map);

endinterface

/* hw/te_addr_compress.sv */
// address selection and byte-granular compression
// also holds the last address sent out in a packet
`include "te_params.svh"

module te_addr_compress (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    te_req_if.addr                req,
    input  logic                  accept_i,
    input  te_pkg::te_keep_bits_t keep_bits_i,
    output te_pkg::te_addr_t      addr_c_o,
    output logic [3:0]            addr_bytes_o
);
    import te_pkg::*;

    te_addr_t   last_addr_q;
    te_addr_t   trap_addr;
    te_addr_t   addr_sel;
    te_addr_t   keep_mask;
    logic [7:0] keep_sum;
    logic       is_sync;
    logic       upd_last;

    assign is_sync = (req.format == F_SYNC);

    // handler address when thaddr, else the faulting pc
    assign trap_addr = req.thaddr ? {req.tvec, 2'b00} : req.epc;

    always_comb begin
        if (is_sync && req.subformat == SF_START) begin
            addr_sel = req.iaddr;
        end else if (is_sync && req.subformat == SF_TRAP) begin
            addr_sel = trap_addr;
        end else begin
            // differential against last emitted
            addr_sel = req.iaddr - last_addr_q;
        end
    end

    // keep_bits rounded up to bytes, capped at a full address
    assign keep_sum     = {1'b0, keep_bits_i} + 8'd7;
    assign addr_bytes_o = (keep_sum[7:3] > 5'd8) ? 4'd8 : keep_sum[6:3];

    // bytes above the kept ones read as zero
    always_comb begin
        for (int i = 0; i < `TE_XLEN / 8; i++) begin
            keep_mask[i*8 +: 8] = {8{i < int'(addr_bytes_o)}};
        end
    end

    assign addr_c_o = addr_sel & keep_mask;

    // context and support packets carry no address
    assign upd_last = accept_i &&
                      !(is_sync && (req.subformat == SF_CONTEXT ||
                                    req.subformat == SF_SUPPORT));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_addr_q <= '0;
        end else if (upd_last) begin
            last_addr_q <= req.iaddr;
        end
    end

endmodule

/* hw/te_branch_map_pack.sv */
// branch count plus the used part of the branch map
// map width is bucketed from the branch count
`include "te_params.svh"

module te_branch_map_pack (
    te_req_if.diff                                           req,
    output logic [`TE_BRANCH_COUNT_LEN+`TE_BRANCH_MAP_LEN-1:0] map_field_o,
    output logic [5:0]                                       map_bits_o
);
    import te_pkg::*;

    te_branches_t   map_w;
    te_branch_map_t map_mask;

    // bucket sizes 0, 1, 9, 17, 25, 31
    always_comb begin
        if (req.branches == 5'd0) begin
            map_w = 5'd0;
        end else if (req.branches == 5'd1) begin
            map_w = 5'd1;
        end else if (req.branches <= 5'd9) begin
            map_w = 5'd9;
        end else if (req.branches <= 5'd17) begin
            map_w = 5'd17;
        end else if (req.branches <= 5'd25) begin
            map_w = 5'd25;
        end else begin
            map_w = 5'd31;
        end
    end

    always_comb begin
        for (int i = 0; i < `TE_BRANCH_MAP_LEN; i++) begin
            map_mask[i] = (i < int'(map_w));
        end
    end

    // count in the low bits, map bits stacked above
    assign map_field_o = {req.branch_map & map_mask, req.branches};
    assign map_bits_o  = {1'b0, map_w} + 6'(`TE_BRANCH_COUNT_LEN);

endmodule

/* hw/te_sync_packer.sv */
// format 3 payload builder for start, trap, context and support
`include "te_params.svh"

module te_sync_packer (
    te_req_if.sync                req,
    input  te_pkg::te_addr_t      addr_c_i,
    input  logic [3:0]            addr_bytes_i,
    output te_pkg::te_payload_t   payload_o,
    output te_pkg::te_used_bits_t used_bits_o
);
    import te_pkg::*;

    // bit positions above format and subformat
    localparam int PrivLsb      = 5;
    localparam int StartAddrLsb = PrivLsb + `TE_PRIV_LEN;
    localparam int CauseLsb     = PrivLsb + `TE_PRIV_LEN;
    localparam int IntrBit      = CauseLsb + `TE_CAUSE_LEN;
    localparam int ThaddrBit    = IntrBit + 1;
    localparam int TrapAddrLsb  = ThaddrBit + 1;

    logic          branch;
    te_cause_t     cause;
    te_addr_t      tval;
    logic          interrupt;
    te_used_bits_t addr_bits;

    // set unless the last branch was taken
    assign branch    = ~(req.branch && req.branch_taken);
    assign cause     = req.lc_tc_mux ? req.tc_cause : req.lc_cause;
    assign tval      = req.lc_tc_mux ? req.tc_tval : req.lc_tval;
    assign interrupt = req.lc_tc_mux ? req.tc_interrupt : req.lc_interrupt;
    assign addr_bits = te_used_bits_t'({addr_bytes_i, 3'b000});

    always_comb begin
        payload_o      = '0;
        payload_o[1:0] = req.format;
        payload_o[3:2] = req.subformat;
        used_bits_o    = 9'd4;
        case (req.subformat)
            SF_START: begin
                payload_o[4]                         = branch;
                payload_o[PrivLsb +: `TE_PRIV_LEN]   = req.priv;
                payload_o[StartAddrLsb +: `TE_XLEN]  = addr_c_i;
                used_bits_o = te_used_bits_t'(StartAddrLsb) + addr_bits;
            end
            SF_TRAP: begin
                payload_o[4]                         = branch;
                payload_o[PrivLsb +: `TE_PRIV_LEN]   = req.priv;
                payload_o[CauseLsb +: `TE_CAUSE_LEN] = cause;
                payload_o[IntrBit]                   = interrupt;
                payload_o[ThaddrBit]                 = req.thaddr;
                payload_o[TrapAddrLsb +: `TE_XLEN]   = addr_c_i;
                // full tval right after the kept address bytes
                payload_o = payload_o |
                            (te_payload_t'(tval) << (te_used_bits_t'(TrapAddrLsb) + addr_bits));
                used_bits_o = te_used_bits_t'(TrapAddrLsb + `TE_XLEN) + addr_bits;
            end
            SF_CONTEXT: begin
                payload_o[4 +: `TE_PRIV_LEN] = req.priv;
                used_bits_o = 9'd4 + 9'(`TE_PRIV_LEN);
            end
            SF_SUPPORT: begin
                payload_o[4]    = req.ienable;
                payload_o[5]    = req.encoder_mode;
                payload_o[7:6]  = req.qual_status;
                payload_o[10:8] = req.ioptions;
                used_bits_o = 9'd11;
            end
        endcase
    end

endmodule

/* hw/te_diff_packer.sv */
// format 1 and format 2 payload builder
// flags sit above the compressed address
`include "te_params.svh"

module te_diff_packer (
    te_req_if.diff                                           req,
    input  te_pkg::te_addr_t                                 addr_c_i,
    input  logic [3:0]                                       addr_bytes_i,
    input  logic [`TE_BRANCH_COUNT_LEN+`TE_BRANCH_MAP_LEN-1:0] map_field_i,
    input  logic [5:0]                                       map_bits_i,
    output te_pkg::te_payload_t                              payload_o,
    output te_pkg::te_used_bits_t                            used_bits_o
);
    import te_pkg::*;

    localparam int IrdepthLen = 2 ** `TE_CALL_COUNTER_SIZE;
    localparam int FlagsLen   = 3 + IrdepthLen;

    logic                  notify;
    logic                  updiscon;
    logic                  irreport;
    logic [IrdepthLen-1:0] irdepth;
    te_used_bits_t         addr_bits;
    te_payload_t           tail;
    te_used_bits_t         tail_bits;
    logic                  map_full;

    // no trigger unit, notify mirrors the top address bit
    assign notify   = req.iaddr[`TE_XLEN-1];
    assign updiscon = req.lc_updiscon ? ~notify : notify;
    assign irreport = updiscon;
    assign irdepth  = {IrdepthLen{updiscon}};

    // compressed address, flags directly above
    assign addr_bits = te_used_bits_t'({addr_bytes_i, 3'b000});
    assign tail      = te_payload_t'(addr_c_i) |
                       (te_payload_t'({irdepth, irreport, updiscon, notify}) << addr_bits);
    assign tail_bits = addr_bits + te_used_bits_t'(FlagsLen);

    // full map means the address is implied
    assign map_full = (req.branches >= te_branches_t'(`TE_BRANCH_MAP_LEN));

    always_comb begin
        payload_o      = '0;
        payload_o[1:0] = req.format;
        used_bits_o    = 9'd2;
        case (req.format)
            F_ADDR_ONLY: begin
                payload_o   = payload_o | (tail << 2);
                used_bits_o = tail_bits + 9'd2;
            end
            F_DIFF_DELTA: begin
                payload_o   = payload_o | (te_payload_t'(map_field_i) << 2);
                used_bits_o = te_used_bits_t'(map_bits_i) + 9'd2;
                if (!map_full) begin
                    payload_o   = payload_o | (tail << used_bits_o);
                    used_bits_o = used_bits_o + tail_bits;
                end
            end
            default: begin
                // format 0 not supported, format bits only
                used_bits_o = 9'd2;
            end
        endcase
    end

endmodule

/* hw/te_packet_out.sv */
// packet output register with valid/ready on both sides
// picks the packer by format and turns used bits into bytes
module te_packet_out (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  valid_i,
    output logic                  ready_o,
    input  te_pkg::te_format_e    format_i,
    input  te_pkg::te_payload_t   sync_payload_i,
    input  te_pkg::te_used_bits_t sync_used_i,
    input  te_pkg::te_payload_t   diff_payload_i,
    input  te_pkg::te_used_bits_t diff_used_i,
    output logic                  accept_o,
    output logic                  flush_o,
    output logic                  packet_valid_o,
    input  logic                  packet_ready_i,
    output te_pkg::te_payload_t   packet_payload_o,
    output te_pkg::te_len_t       payload_length_o
);
    import te_pkg::*;

    te_payload_t   payload_d;
    te_used_bits_t used_d;
    te_used_bits_t used_round;

    // free slot, or the held packet leaves this cycle
    assign ready_o  = !packet_valid_o || packet_ready_i;
    assign accept_o = valid_i && ready_o;
    // map is consumed by every accepted request
    assign flush_o  = accept_o;

    assign payload_d  = (format_i == F_SYNC) ? sync_payload_i : diff_payload_i;
    assign used_d     = (format_i == F_SYNC) ? sync_used_i : diff_used_i;
    assign used_round = used_d + 9'd7;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o <= 1'b0;
        end else if (accept_o) begin
            packet_valid_o <= 1'b1;
        end else if (packet_ready_i) begin
            packet_valid_o <= 1'b0;
        end
    end

    // payload held while the sink stalls
    always_ff @(posedge clk_i) begin
        if (accept_o) begin
            packet_payload_o <= payload_d;
            payload_length_o <= used_round[7:3];
        end
    end

endmodule

/* hw/te_packet_emitter.sv */
// trace packet emitter top
// one request in, one packet out through a single output register
`include "te_params.svh"

module te_packet_emitter (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    valid_i,
    output logic                    ready_o,
    input  te_pkg::te_format_e      packet_format_i,
    input  te_pkg::te_sync_sf_e     sync_subformat_i,
    input  te_pkg::te_cause_t       lc_cause_i,
    input  te_pkg::te_addr_t        lc_tval_i,
    input  logic                    lc_interrupt_i,
    input  te_pkg::te_cause_t       tc_cause_i,
    input  te_pkg::te_addr_t        tc_tval_i,
    input  logic                    tc_interrupt_i,
    input  logic                    tc_branch_i,
    input  logic                    tc_branch_taken_i,
    input  te_pkg::te_priv_t        tc_priv_i,
    input  te_pkg::te_addr_t        tc_iaddr_i,
    input  logic                    lc_tc_mux_i,
    input  logic                    thaddr_i,
    input  logic [`TE_XLEN-1:2]     tc_tvec_i,
    input  te_pkg::te_addr_t        lc_epc_i,
    input  logic                    tc_ienable_i,
    input  logic                    encoder_mode_i,
    input  te_pkg::te_qual_status_e qual_status_i,
    input  te_pkg::te_ioptions_e    ioptions_i,
    input  logic                    lc_updiscon_i,
    input  te_pkg::te_branches_t    branches_i,
    input  te_pkg::te_branch_map_t  branch_map_i,
    input  te_pkg::te_keep_bits_t   keep_bits_i,
    output logic                    packet_valid_o,
    input  logic                    packet_ready_i,
    output te_pkg::te_payload_t     packet_payload_o,
    output te_pkg::te_len_t         payload_length_o,
    output logic                    branch_map_flush_o
);
    import te_pkg::*;

    te_addr_t      addr_c;
    logic [3:0]    addr_bytes;
    logic [`TE_BRANCH_COUNT_LEN+`TE_BRANCH_MAP_LEN-1:0] map_field;
    logic [5:0]    map_bits;
    te_payload_t   sync_payload;
    te_used_bits_t sync_used;
    te_payload_t   diff_payload;
    te_used_bits_t diff_used;
    logic          accept;

    te_req_if req ();

    assign req.format       = packet_format_i;
    assign req.subformat    = sync_subformat_i;
    assign req.priv         = tc_priv_i;
    assign req.iaddr        = tc_iaddr_i;
    assign req.branch       = tc_branch_i;
    assign req.branch_taken = tc_branch_taken_i;
    assign req.lc_cause     = lc_cause_i;
    assign req.lc_tval      = lc_tval_i;
    assign req.lc_interrupt = lc_interrupt_i;
    assign req.tc_cause     = tc_cause_i;
    assign req.tc_tval      = tc_tval_i;
    assign req.tc_interrupt = tc_interrupt_i;
    assign req.lc_tc_mux    = lc_tc_mux_i;
    assign req.thaddr       = thaddr_i;
    assign req.tvec         = tc_tvec_i;
    assign req.epc          = lc_epc_i;
    assign req.ienable      = tc_ienable_i;
    assign req.encoder_mode = encoder_mode_i;
    assign req.qual_status  = qual_status_i;
    assign req.ioptions     = ioptions_i;
    assign req.lc_updiscon  = lc_updiscon_i;
    assign req.branches     = branches_i;
    assign req.branch_map   = branch_map_i;

    te_addr_compress i_addr_compress (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req          (req),
        .accept_i     (accept),
        .keep_bits_i  (keep_bits_i),
        .addr_c_o     (addr_c),
        .addr_bytes_o (addr_bytes)
    );

    te_branch_map_pack i_branch_map_pack (
        .req         (req),
        .map_field_o (map_field),
        .map_bits_o  (map_bits)
    );

    te_sync_packer i_sync_packer (
        .req          (req),
        .addr_c_i     (addr_c),
        .addr_bytes_i (addr_bytes),
        .payload_o    (sync_payload),
        .used_bits_o  (sync_used)
    );

    te_diff_packer i_diff_packer (
        .req          (req),
        .addr_c_i     (addr_c),
        .addr_bytes_i (addr_bytes),
        .map_field_i  (map_field),
        .map_bits_i   (map_bits),
        .payload_o    (diff_payload),
        .used_bits_o  (diff_used)
    );

    // single register stage, one cycle to packet_valid_o
    te_packet_out i_packet_out (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .valid_i          (valid_i),
        .ready_o          (ready_o),
        .format_i         (packet_format_i),
        .sync_payload_i   (sync_payload),
        .sync_used_i      (sync_used),
        .diff_payload_i   (diff_payload),
        .diff_used_i      (diff_used),
        .accept_o         (accept),
        .flush_o          (branch_map_flush_o),
        .packet_valid_o   (packet_valid_o),
        .packet_ready_i   (packet_ready_i),
        .packet_payload_o (packet_payload_o),
        .payload_length_o (payload_length_o)
    );

endmodule

/* dv/tb_te_packet_emitter.sv */
// testbench for the trace packet emitter
// replays requests from the stimulus file and checks payload, length and handshakes
`include "te_params.svh"

module tb_te_packet_emitter;
    timeunit 1ns;
    timeprecision 1ps;
    import te_pkg::*;

    localparam int MaxTests = 64;
    localparam int NumFields = 28;

    logic clk_i;
    logic rst_ni;
    logic valid_i;
    logic ready_o;
    te_format_e packet_format_i;
    te_sync_sf_e sync_subformat_i;
    te_cause_t lc_cause_i;
    te_addr_t lc_tval_i;
    logic lc_interrupt_i;
    te_cause_t tc_cause_i;
    te_addr_t tc_tval_i;
    logic tc_interrupt_i;
    logic tc_branch_i;
    logic tc_branch_taken_i;
    te_priv_t tc_priv_i;
    te_addr_t tc_iaddr_i;
    logic lc_tc_mux_i;
    logic thaddr_i;
    logic [`TE_XLEN-1:2] tc_tvec_i;
    te_addr_t lc_epc_i;
    logic tc_ienable_i;
    logic encoder_mode_i;
    te_qual_status_e qual_status_i;
    te_ioptions_e ioptions_i;
    logic lc_updiscon_i;
    te_branches_t branches_i;
    te_branch_map_t branch_map_i;
    te_keep_bits_t keep_bits_i;
    logic packet_valid_o;
    logic packet_ready_i;
    te_payload_t packet_payload_o;
    te_len_t payload_length_o;
    logic branch_map_flush_o;

    // raw text of each test line, parsed again when applied
    string lines[MaxTests];
    int stalls[MaxTests];
    int num_tests;
    int cycle_count;
    int cycle_limit;
    int fail_count;
    bit test_failed;

    te_packet_emitter i_dut (.*);

    always #10 clk_i = ~clk_i;

    // run limit from the number of tests and their stalls
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, DUT handshake never completed", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic load_stimulus();
        int fd;
        string line;
        string nm;
        logic [159:0] f [NumFields-1];
        int n;
        fd = $fopen("dv/te_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file dv/te_stimulus.txt");
            fail_count++;
            return;
        end
        while (!$feof(fd) && num_tests < MaxTests) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        nm, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                        f[19], f[20], f[21], f[22], f[23], f[24], f[25], f[26]);
            if (n != NumFields) begin
                $display("malformed stimulus line: %s", line);
                fail_count++;
                continue;
            end
            lines[num_tests] = line;
            stalls[num_tests] = int'(f[24]);
            num_tests++;
        end
        $fclose(fd);
    endtask

    task automatic error(input string msg);
        $display("%s", msg);
        test_failed = 1'b1;
    endtask

    task automatic apply_request(input int idx);
        string nm;
        logic [159:0] f [NumFields-1];
        te_payload_t exp_payload;
        te_len_t exp_len;
        te_payload_t got_payload;
        te_len_t got_len;
        int stall;
        void'($sscanf(lines[idx],
                      "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      nm, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                      f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                      f[19], f[20], f[21], f[22], f[23], f[24], f[25], f[26]));
        stall = int'(f[24]);
        exp_payload = f[25];
        exp_len = f[26][4:0];
        test_failed = 1'b0;

        @(negedge clk_i);
        packet_format_i = te_format_e'(f[0][1:0]);
        sync_subformat_i = te_sync_sf_e'(f[1][1:0]);
        tc_priv_i = f[2][1:0];
        tc_iaddr_i = f[3][63:0];
        tc_branch_i = f[4][0];
        tc_branch_taken_i = f[5][0];
        lc_cause_i = f[6][4:0];
        lc_tval_i = f[7][63:0];
        lc_interrupt_i = f[8][0];
        tc_cause_i = f[9][4:0];
        tc_tval_i = f[10][63:0];
        tc_interrupt_i = f[11][0];
        lc_tc_mux_i = f[12][0];
        thaddr_i = f[13][0];
        tc_tvec_i = f[14][61:0];
        lc_epc_i = f[15][63:0];
        tc_ienable_i = f[16][0];
        encoder_mode_i = f[17][0];
        qual_status_i = te_qual_status_e'(f[18][1:0]);
        ioptions_i = te_ioptions_e'(f[19][2:0]);
        lc_updiscon_i = f[20][0];
        branches_i = f[21][4:0];
        branch_map_i = f[22][30:0];
        keep_bits_i = f[23][6:0];
        valid_i = 1'b1;
        packet_ready_i = (stall == 0);
        // combinational handshake outputs settle after the drive
        #1;

        while (!ready_o) begin
            @(negedge clk_i);
            #1;
        end
        if (!branch_map_flush_o) begin
            error({nm, ": branch_map_flush_o low in acceptance cycle"});
        end

        // acceptance at the last posedge, packet shows now
        @(negedge clk_i);
        valid_i = 1'b0;
        #1;
        if (!packet_valid_o) begin
            error({nm, ": packet_valid_o did not rise one cycle after acceptance"});
        end
        if (branch_map_flush_o) begin
            error({nm, ": branch_map_flush_o high outside acceptance"});
        end
        got_payload = packet_payload_o;
        got_len = payload_length_o;

        // output held while the sink stalls
        repeat (stall) begin
            if (ready_o) begin
                error({nm, ": ready_o high while output register is stalled"});
            end
            @(negedge clk_i);
            if (!packet_valid_o || packet_payload_o != got_payload ||
                payload_length_o != got_len) begin
                error({nm, ": packet changed or dropped under back-pressure"});
            end
        end
        packet_ready_i = 1'b1;
        @(negedge clk_i);
        if (packet_valid_o) begin
            error({nm, ": packet_valid_o still high after sink accepted"});
        end

        if (got_payload != exp_payload) begin
            $display("Fail %s: payload expected %h actual %h", nm, exp_payload, got_payload);
            test_failed = 1'b1;
        end
        if (got_len != exp_len) begin
            $display("Fail %s: length expected %0d actual %0d", nm, exp_len, got_len);
            test_failed = 1'b1;
        end
        if (test_failed) begin
            fail_count++;
        end else begin
            $display("ok   %s", nm);
        end
    endtask

    initial begin
        int total_stall;
        clk_i = 1'b0;
        rst_ni = 1'b0;
        valid_i = 1'b0;
        packet_ready_i = 1'b0;
        packet_format_i = F_SYNC;
        sync_subformat_i = SF_START;
        lc_cause_i = '0;
        lc_tval_i = '0;
        lc_interrupt_i = 1'b0;
        tc_cause_i = '0;
        tc_tval_i = '0;
        tc_interrupt_i = 1'b0;
        tc_branch_i = 1'b0;
        tc_branch_taken_i = 1'b0;
        tc_priv_i = '0;
        tc_iaddr_i = '0;
        lc_tc_mux_i = 1'b0;
        thaddr_i = 1'b0;
        tc_tvec_i = '0;
        lc_epc_i = '0;
        tc_ienable_i = 1'b0;
        encoder_mode_i = 1'b0;
        qual_status_i = QS_NO_CHANGE;
        ioptions_i = DELTA_ADDRESS;
        lc_updiscon_i = 1'b0;
        branches_i = '0;
        branch_map_i = '0;
        keep_bits_i = '0;
        cycle_count = 0;
        cycle_limit = 1000;
        fail_count = 0;
        num_tests = 0;
        total_stall = 0;

        load_stimulus();
        for (int i = 0; i < num_tests; i++) begin
            total_stall += stalls[i];
        end
        // reset fits in the per-test margin
        cycle_limit = 8 * num_tests + total_stall;

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        if (!ready_o || packet_valid_o || branch_map_flush_o) begin
            $display("handshake outputs wrong after reset");
            fail_count++;
        end

        for (int i = 0; i < num_tests; i++) begin
            apply_request(i);
        end

        $display("tests %0d, failed %0d", num_tests, fail_count);
        if (fail_count == 0 && num_tests > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+hw
hw/te_pkg.sv
hw/te_req_if.sv
hw/te_addr_compress.sv
hw/te_branch_map_pack.sv
hw/te_sync_packer.sv
hw/te_diff_packer.sv
hw/te_packet_out.sv
hw/te_packet_emitter.sv
dv/tb_te_packet_emitter.sv

/* dv/te_stimulus.txt */
# name fmt sf priv iaddr br tk lc_cause lc_tval lc_int tc_cause tc_tval tc_int lctc thaddr tvec epc
#   ien enc qs iopt upd branches map keep stall exp_payload exp_len (all hex except name)
sync_start_k16 3 0 3 1122334455667788 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10 2 3bc473 3
sync_trap_tvec 3 1 1 1000 1 1 5 ab 1 0 0 0 0 1 40 0 0 0 0 0 0 0 0 9 0 2ac04032a7 c
sync_trap_epc 3 1 0 2000 0 0 0 0 0 1f 1 0 1 0 0 ffeeddccbbaa9988 0 0 0 0 0 0 0 28 0 732eeaa6620f97 f
sync_context 3 2 2 9999 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2b 1
sync_support 3 3 0 9999 0 0 0 0 0 0 0 0 0 0 0 0 1 0 2 1 0 0 0 0 0 19f 2
addr_only_diff 2 0 0 2345 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 c 0 d16 4
addr_only_top1 2 0 0 8000000000002345 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 0 1ffc02 3
addr_only_updis 2 0 0 8000000000002400 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 7 0 6ee 3
addr_only_full 2 0 0 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 40 3 1ff9ffffffffffff7042 a
diff_br0 1 0 0 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 7fffffff 0 0 1 3
diff_br1 1 0 0 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 7fffffff 0 0 85 3
diff_br9 1 0 0 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9 7ffff2aa 0 0 5525 4
diff_br17 1 0 0 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 7fffffff 0 0 ffffc5 5
diff_br25 1 0 0 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 19 1234567 0 0 91a2b3e5 6
diff_br30 1 0 0 30 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1e 7fffffff 8 0 83ffffffff9 8
diff_br31_full 1 0 0 30 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1f 55555555 8 0 2aaaaaaafd 5
